// File: design/dcache_pkg.sv
// geometry is fixed at 64 lines of 16 bytes with 32-bit words; widths below must stay consistent
package dcache_pkg;

    // ******************************************************************
    // widths
    // ******************************************************************

    localparam int unsigned addr_w     = 32;
    localparam int unsigned word_w     = 32;
    localparam int unsigned be_w       = word_w / 8;
    localparam int unsigned byte_off_w = $clog2(be_w);
    localparam int unsigned line_words = 4;
    localparam int unsigned line_w     = line_words * word_w;
    localparam int unsigned offset_w   = $clog2(line_w / 8);
    localparam int unsigned index_w    = 6;
    localparam int unsigned tag_w      = addr_w - index_w - offset_w;

    // ******************************************************************
    // types
    // ******************************************************************

    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [word_w-1:0]  word_t;
    typedef logic [be_w-1:0]    be_t;
    typedef logic [line_w-1:0]  line_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [tag_w-1:0]   tag_t;

    // one tag store entry, the valid bit sits on top so a zeroed entry is invalid
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, WB_REQ, WB_WAIT, FILL_REQ, FILL_WAIT
    } ctrl_state_t;

    // ******************************************************************
    // address and line helpers
    // ******************************************************************

    function automatic tag_t addr_tag(addr_t addr);
        return addr[addr_w-1 -: tag_w];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[offset_w +: index_w];
    endfunction

    // the low byte-offset bits are ignored, loads are always whole aligned words
    function automatic word_t line_word(line_t line, logic [offset_w-1:0] offset);
        return line[offset[offset_w-1:byte_off_w]*word_w +: word_w];
    endfunction

    // only the bytes with their enable set are taken from wdata
    function automatic line_t line_merge(line_t line, logic [offset_w-1:0] offset,
                                         word_t wdata, be_t be);
        line_t res;
        word_t w;
        res = line;
        w = line_word(line, offset);
        for (int b = 0; b < be_w; b++) begin
            if (be[b]) begin
                w[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        res[offset[offset_w-1:byte_off_w]*word_w +: word_w] = w;
        return res;
    endfunction

endpackage

// File: design/dcache_store_ram.sv
// single port, one cycle read latency; depth must be a power of two no larger than the index range
`timescale 1ns/1ps

module dcache_store_ram #(
    parameter type entry_t        = logic [31:0],
    parameter int  depth          = 64,
    parameter bit  clear_on_reset = 1'b0
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               en_i,
    input  logic               we_i,
    input  dcache_pkg::index_t addr_i,
    input  entry_t             wdata_i,
    output entry_t             rdata_o
);

    localparam int aw = $clog2(depth);

    entry_t mem [depth];

    // only the low index bits select an entry when the array is smaller than the index range
    logic [aw-1:0] row;

    assign row = addr_i[aw-1:0];

    // array write, the tag store is wiped while reset is held so all lines start invalid
    always_ff @(posedge clk_i) begin
        if (clear_on_reset && !rst_ni) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (en_i && we_i) begin
            mem[row] <= wdata_i;
        end
    end

    // read port, the output keeps its value through writes and idle cycles
    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            rdata_o <= mem[row];
        end
    end

endmodule

// File: design/dcache_port_arbiter.sv
// load always wins over store; grants only while accept_i is high and requests must hold until granted
`timescale 1ns/1ps

module dcache_port_arbiter (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              accept_i,
    input  logic              ld_req_i,
    input  dcache_pkg::addr_t ld_addr_i,
    input  logic              st_req_i,
    input  dcache_pkg::addr_t st_addr_i,
    input  dcache_pkg::word_t st_wdata_i,
    input  dcache_pkg::be_t   st_be_i,
    output logic              ld_gnt_o,
    output logic              st_gnt_o,
    output logic              start_o,
    output dcache_pkg::addr_t start_addr_o,
    output logic              cur_is_store_o,
    output dcache_pkg::addr_t cur_addr_o,
    output dcache_pkg::word_t cur_wdata_o,
    output dcache_pkg::be_t   cur_be_o
);

    // ******************************************************************
    // selection
    // ******************************************************************

    // a pending store is held off for as long as a load is requested
    assign ld_gnt_o = accept_i & ld_req_i;
    assign st_gnt_o = accept_i & st_req_i & ~ld_req_i;
    assign start_o  = ld_gnt_o | st_gnt_o;

    // the stores start their read with this address in the grant cycle
    assign start_addr_o = ld_req_i ? ld_addr_i : st_addr_i;

    // ******************************************************************
    // request in service
    // ******************************************************************

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            cur_is_store_o <= 1'b0;
        end else if (start_o) begin
            cur_is_store_o <= st_gnt_o;
        end
    end

    // store data and enables are sampled together with the grant
    always_ff @(posedge clk_i) begin
        if (start_o) begin
            cur_addr_o  <= start_addr_o;
            cur_wdata_o <= st_wdata_i;
            cur_be_o    <= st_be_i;
        end
    end

endmodule

// File: design/dcache_controller.sv
// blocking controller, one request at a time; memory must answer every request with one return strobe
`timescale 1ns/1ps

module dcache_controller (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   start_i,
    input  logic                   cur_is_store_i,
    input  dcache_pkg::addr_t      cur_addr_i,
    input  dcache_pkg::word_t      cur_wdata_i,
    input  dcache_pkg::be_t        cur_be_i,
    input  dcache_pkg::tag_entry_t tag_rdata_i,
    input  dcache_pkg::line_t      line_rdata_i,
    input  logic                   mem_ack_i,
    input  logic                   mem_rtrn_vld_i,
    input  dcache_pkg::line_t      mem_rtrn_data_i,
    output logic                   accept_o,
    output logic                   tag_en_o,
    output logic                   tag_we_o,
    output dcache_pkg::tag_entry_t tag_wdata_o,
    output logic                   data_en_o,
    output logic                   data_we_o,
    output dcache_pkg::line_t      data_wdata_o,
    output dcache_pkg::index_t     store_addr_o,
    output logic                   ld_rvalid_o,
    output dcache_pkg::word_t      ld_rdata_o,
    output logic                   miss_o,
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output dcache_pkg::addr_t      mem_addr_o,
    output dcache_pkg::line_t      mem_wdata_o
);

    // ******************************************************************
    // declarations
    // ******************************************************************

    dcache_pkg::ctrl_state_t state_q, state_d;

    // victim line and its tag, kept while the writeback is in flight
    dcache_pkg::line_t victim_line_q;
    dcache_pkg::tag_t  victim_tag_q;
    logic              capture_victim;

    // fields of the request in service
    dcache_pkg::tag_t            cur_tag;
    dcache_pkg::index_t          cur_index;
    logic [dcache_pkg::offset_w-1:0] cur_offset;
    logic                        hit;

    assign cur_tag    = dcache_pkg::addr_tag(cur_addr_i);
    assign cur_index  = dcache_pkg::addr_index(cur_addr_i);
    assign cur_offset = cur_addr_i[dcache_pkg::offset_w-1:0];

    // the tag entry read in the grant cycle is valid during LOOKUP
    assign hit = tag_rdata_i.valid && (tag_rdata_i.tag == cur_tag);

    // grants are only taken while nothing is in service
    assign accept_o = (state_q == dcache_pkg::IDLE);

    // after the grant cycle every access goes to the line of the captured request
    assign store_addr_o = cur_index;

    // a read is started by a grant, writes enable the stores on their own
    assign tag_en_o  = start_i | tag_we_o;
    assign data_en_o = start_i | data_we_o;

    // ******************************************************************
    // memory port
    // ******************************************************************

    // line-aligned addresses, the victim one while writing back
    assign mem_addr_o = (state_q == dcache_pkg::WB_REQ)
                      ? {victim_tag_q, cur_index, {dcache_pkg::offset_w{1'b0}}}
                      : {cur_tag, cur_index, {dcache_pkg::offset_w{1'b0}}};

    assign mem_wdata_o = victim_line_q;

    // ******************************************************************
    // next state and store writes
    // ******************************************************************

    always_comb begin
        state_d        = state_q;
        capture_victim = 1'b0;
        tag_we_o       = 1'b0;
        tag_wdata_o    = '0;
        data_we_o      = 1'b0;
        data_wdata_o   = '0;
        ld_rvalid_o    = 1'b0;
        ld_rdata_o     = '0;
        miss_o         = 1'b0;
        mem_req_o      = 1'b0;
        mem_we_o       = 1'b0;

        case (state_q)
            dcache_pkg::IDLE: begin
                if (start_i) begin
                    state_d = dcache_pkg::LOOKUP;
                end
            end

            dcache_pkg::LOOKUP: begin
                if (hit && !cur_is_store_i) begin
                    // load hit, the word goes out straight from the read line
                    ld_rvalid_o = 1'b1;
                    ld_rdata_o  = dcache_pkg::line_word(line_rdata_i, cur_offset);
                    state_d     = dcache_pkg::IDLE;
                end else if (hit) begin
                    // store hit merges into the line and marks it dirty
                    tag_we_o          = 1'b1;
                    tag_wdata_o.valid = 1'b1;
                    tag_wdata_o.dirty = 1'b1;
                    tag_wdata_o.tag   = cur_tag;
                    data_we_o         = 1'b1;
                    data_wdata_o      = dcache_pkg::line_merge(line_rdata_i, cur_offset,
                                                               cur_wdata_i, cur_be_i);
                    state_d           = dcache_pkg::IDLE;
                end else begin
                    miss_o = 1'b1;
                    // a dirty victim must reach memory before the fill overwrites it
                    if (tag_rdata_i.valid && tag_rdata_i.dirty) begin
                        capture_victim = 1'b1;
                        state_d        = dcache_pkg::WB_REQ;
                    end else begin
                        state_d = dcache_pkg::FILL_REQ;
                    end
                end
            end

            dcache_pkg::WB_REQ: begin
                mem_req_o = 1'b1;
                mem_we_o  = 1'b1;
                if (mem_ack_i) begin
                    state_d = dcache_pkg::WB_WAIT;
                end
            end

            dcache_pkg::WB_WAIT: begin
                if (mem_rtrn_vld_i) begin
                    state_d = dcache_pkg::FILL_REQ;
                end
            end

            dcache_pkg::FILL_REQ: begin
                mem_req_o = 1'b1;
                if (mem_ack_i) begin
                    state_d = dcache_pkg::FILL_WAIT;
                end
            end

            dcache_pkg::FILL_WAIT: begin
                if (mem_rtrn_vld_i) begin
                    // fresh line is clean unless a store lands in it right away
                    tag_we_o          = 1'b1;
                    tag_wdata_o.valid = 1'b1;
                    tag_wdata_o.dirty = cur_is_store_i;
                    tag_wdata_o.tag   = cur_tag;
                    data_we_o         = 1'b1;
                    data_wdata_o      = cur_is_store_i
                                      ? dcache_pkg::line_merge(mem_rtrn_data_i, cur_offset,
                                                               cur_wdata_i, cur_be_i)
                                      : mem_rtrn_data_i;
                    ld_rvalid_o       = ~cur_is_store_i;
                    ld_rdata_o        = dcache_pkg::line_word(mem_rtrn_data_i, cur_offset);
                    state_d           = dcache_pkg::IDLE;
                end
            end

            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    // ******************************************************************
    // registers
    // ******************************************************************

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture_victim) begin
            victim_line_q <= line_rdata_i;
            victim_tag_q  <= tag_rdata_i.tag;
        end
    end

endmodule

// File: design/dcache_top.sv
// direct-mapped write-back cache top; CPU requests hold until granted, memory holds one transaction
`timescale 1ns/1ps

module dcache_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              ld_req_i,
    input  dcache_pkg::addr_t ld_addr_i,
    input  logic              st_req_i,
    input  dcache_pkg::addr_t st_addr_i,
    input  dcache_pkg::word_t st_wdata_i,
    input  dcache_pkg::be_t   st_be_i,
    input  logic              mem_ack_i,
    input  logic              mem_rtrn_vld_i,
    input  dcache_pkg::line_t mem_rtrn_data_i,
    output logic              ld_gnt_o,
    output logic              ld_rvalid_o,
    output dcache_pkg::word_t ld_rdata_o,
    output logic              st_gnt_o,
    output logic              miss_o,
    output logic              mem_req_o,
    output logic              mem_we_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::line_t mem_wdata_o
);

    logic                   accept, start, cur_is_store;
    dcache_pkg::addr_t      start_addr, cur_addr;
    dcache_pkg::word_t      cur_wdata;
    dcache_pkg::be_t        cur_be;
    logic                   tag_en, tag_we, data_en, data_we;
    dcache_pkg::tag_entry_t tag_wdata, tag_rdata;
    dcache_pkg::line_t      data_wdata, line_rdata;
    dcache_pkg::index_t     store_addr, ram_addr;

    // the new request's index drives the stores in its grant cycle only
    assign ram_addr = start ? dcache_pkg::addr_index(start_addr) : store_addr;

    dcache_port_arbiter u_arbiter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .accept_i       (accept),
        .ld_req_i       (ld_req_i),
        .ld_addr_i      (ld_addr_i),
        .st_req_i       (st_req_i),
        .st_addr_i      (st_addr_i),
        .st_wdata_i     (st_wdata_i),
        .st_be_i        (st_be_i),
        .ld_gnt_o       (ld_gnt_o),
        .st_gnt_o       (st_gnt_o),
        .start_o        (start),
        .start_addr_o   (start_addr),
        .cur_is_store_o (cur_is_store),
        .cur_addr_o     (cur_addr),
        .cur_wdata_o    (cur_wdata),
        .cur_be_o       (cur_be)
    );

    dcache_controller u_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .start_i         (start),
        .cur_is_store_i  (cur_is_store),
        .cur_addr_i      (cur_addr),
        .cur_wdata_i     (cur_wdata),
        .cur_be_i        (cur_be),
        .tag_rdata_i     (tag_rdata),
        .line_rdata_i    (line_rdata),
        .mem_ack_i       (mem_ack_i),
        .mem_rtrn_vld_i  (mem_rtrn_vld_i),
        .mem_rtrn_data_i (mem_rtrn_data_i),
        .accept_o        (accept),
        .tag_en_o        (tag_en),
        .tag_we_o        (tag_we),
        .tag_wdata_o     (tag_wdata),
        .data_en_o       (data_en),
        .data_we_o       (data_we),
        .data_wdata_o    (data_wdata),
        .store_addr_o    (store_addr),
        .ld_rvalid_o     (ld_rvalid_o),
        .ld_rdata_o      (ld_rdata_o),
        .miss_o          (miss_o),
        .mem_req_o       (mem_req_o),
        .mem_we_o        (mem_we_o),
        .mem_addr_o      (mem_addr_o),
        .mem_wdata_o     (mem_wdata_o)
    );

    // tag store is cleared in reset so every line starts invalid
    dcache_store_ram #(
        .entry_t        (dcache_pkg::tag_entry_t),
        .depth          (2 ** dcache_pkg::index_w),
        .clear_on_reset (1'b1)
    ) u_tag_ram (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .en_i    (tag_en),
        .we_i    (tag_we),
        .addr_i  (ram_addr),
        .wdata_i (tag_wdata),
        .rdata_o (tag_rdata)
    );

    dcache_store_ram #(
        .entry_t        (dcache_pkg::line_t),
        .depth          (2 ** dcache_pkg::index_w),
        .clear_on_reset (1'b0)
    ) u_data_ram (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .en_i    (data_en),
        .we_i    (data_we),
        .addr_i  (ram_addr),
        .wdata_i (data_wdata),
        .rdata_o (line_rdata)
    );

endmodule

// File: verification/dcache_mem_model.sv
// ack comes 0 to 3 cycles after a request from a fixed seed; unwritten words read as address xor 32'h5a5a0000
`timescale 1ns/1ps

module dcache_mem_model (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_i,
    input  logic              we_i,
    input  dcache_pkg::addr_t addr_i,
    input  dcache_pkg::line_t wdata_i,
    output logic              ack_o,
    output logic              rtrn_vld_o,
    output dcache_pkg::line_t rtrn_data_o
);

    // lines that were written back, keyed by line address
    dcache_pkg::line_t lines [dcache_pkg::addr_t];

    integer            seed;
    int                delay;
    logic              busy;
    logic              acc_we;
    dcache_pkg::addr_t acc_addr;
    dcache_pkg::line_t acc_wdata;

    function automatic dcache_pkg::line_t read_line(dcache_pkg::addr_t line_addr);
        dcache_pkg::line_t l;
        if (lines.exists(line_addr)) begin
            return lines[line_addr];
        end
        for (int w = 0; w < dcache_pkg::line_words; w++) begin
            l[w*dcache_pkg::word_w +: dcache_pkg::word_w] =
                (line_addr + dcache_pkg::addr_t'(4 * w)) ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    // outputs change 1 ns after the rising edge like the other testbench drivers
    initial begin
        seed        = 32'h4ecf933c;
        ack_o       = 1'b0;
        rtrn_vld_o  = 1'b0;
        rtrn_data_o = '0;
        busy        = 1'b0;
        delay       = 0;
        forever begin
            @(posedge clk_i);
            #1;
            rtrn_vld_o = 1'b0;
            if (!rst_ni) begin
                ack_o = 1'b0;
                busy  = 1'b0;
            end else if (ack_o) begin
                // the handshake took place on the edge just passed, the return follows now
                ack_o = 1'b0;
                busy  = 1'b0;
                if (acc_we) begin
                    lines[acc_addr] = acc_wdata;
                end else begin
                    rtrn_data_o = read_line(acc_addr);
                end
                rtrn_vld_o = 1'b1;
            end else begin
                if (!busy && req_i) begin
                    busy  = 1'b1;
                    delay = $unsigned($random(seed)) % 4;
                end else if (busy && delay > 0) begin
                    delay = delay - 1;
                end
                if (busy && delay == 0) begin
                    ack_o     = 1'b1;
                    acc_we    = we_i;
                    acc_addr  = addr_i;
                    acc_wdata = wdata_i;
                end
            end
        end
    end

endmodule

// File: verification/dcache_assert.sv
// port names follow the cache top level; checks hold only while reset is released
`timescale 1ns/1ps

module dcache_assert (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              ld_req_i,
    input logic              ld_gnt_o,
    input logic              st_gnt_o,
    input logic              miss_o,
    input logic              mem_req_o,
    input logic              mem_we_o,
    input logic              mem_ack_i,
    input dcache_pkg::addr_t mem_addr_o
);

    // never more than one port granted in a cycle
    one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ld_gnt_o && st_gnt_o))
        else $error("load and store granted in the same cycle");

    // a pending load always keeps the store waiting
    load_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ld_req_i |-> !st_gnt_o)
        else $error("store granted while a load was requested");

    // the memory request must not move until it is acknowledged
    mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o))
        else $error("memory request changed before its ack");

    mem_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o |-> mem_addr_o[dcache_pkg::offset_w-1:0] == '0)
        else $error("memory address not line aligned");

    // miss is a single cycle pulse from LOOKUP
    miss_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_o |=> !miss_o)
        else $error("miss held longer than one cycle");

endmodule

bind dcache_top dcache_assert u_assert (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ld_req_i   (ld_req_i),
    .ld_gnt_o   (ld_gnt_o),
    .st_gnt_o   (st_gnt_o),
    .miss_o     (miss_o),
    .mem_req_o  (mem_req_o),
    .mem_we_o   (mem_we_o),
    .mem_ack_i  (mem_ack_i),
    .mem_addr_o (mem_addr_o)
);

// File: verification/dcache_tb.sv
// reads verification/dcache_patterns.txt relative to the run directory; the first wrong value ends the run
`timescale 1ns/1ps

module dcache_tb;

    // ******************************************************************
    // pattern storage and run limits
    // ******************************************************************

    localparam int          max_pat  = 32;
    localparam int          pat_cols = 7;
    localparam logic [31:0] no_wb    = 32'hffffffff;

    // each row of the pattern file fills pat_cols consecutive words
    logic [31:0] pat_words [max_pat*pat_cols];
    int          n_pat;
    int          cur_pat;
    int          cycle_limit = 0;
    int          cycle_cnt = 0;

    logic              clk_i;
    logic              rst_ni;
    logic              ld_req, st_req;
    dcache_pkg::addr_t ld_addr, st_addr;
    dcache_pkg::word_t st_wdata;
    dcache_pkg::be_t   st_be;
    logic              ld_gnt, st_gnt, ld_rvalid, miss;
    dcache_pkg::word_t ld_rdata;
    logic              mem_req, mem_we, mem_ack, mem_rtrn_vld;
    dcache_pkg::addr_t mem_addr;
    dcache_pkg::line_t mem_wdata, mem_rtrn_data;

    // what was seen at the falling edges of the pattern in progress
    int                cyc;
    int                miss_cnt;
    logic              mem_seen, last_we, fill_done;
    logic [31:0]       wb_addr;
    logic              ld_gnt_seen, st_gnt_seen, rv_seen, st_at_ld;
    int                ld_gnt_cyc, st_gnt_cyc, rv_cyc;
    dcache_pkg::word_t rv_data;

    dcache_top dut0 (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ld_req_i        (ld_req),
        .ld_addr_i       (ld_addr),
        .st_req_i        (st_req),
        .st_addr_i       (st_addr),
        .st_wdata_i      (st_wdata),
        .st_be_i         (st_be),
        .mem_ack_i       (mem_ack),
        .mem_rtrn_vld_i  (mem_rtrn_vld),
        .mem_rtrn_data_i (mem_rtrn_data),
        .ld_gnt_o        (ld_gnt),
        .ld_rvalid_o     (ld_rvalid),
        .ld_rdata_o      (ld_rdata),
        .st_gnt_o        (st_gnt),
        .miss_o          (miss),
        .mem_req_o       (mem_req),
        .mem_we_o        (mem_we),
        .mem_addr_o      (mem_addr),
        .mem_wdata_o     (mem_wdata)
    );

    dcache_mem_model mem0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (mem_req),
        .we_i        (mem_we),
        .addr_i      (mem_addr),
        .wdata_i     (mem_wdata),
        .ack_o       (mem_ack),
        .rtrn_vld_o  (mem_rtrn_vld),
        .rtrn_data_o (mem_rtrn_data)
    );

    // 4 ns period
    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            abort_run("timeout, the cache stopped answering requests");
        end
    end

    // ******************************************************************
    // reporting and observation
    // ******************************************************************

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED pattern %0d %s: expected %h, actual %h", cur_pat, what, exp, act);
            abort_run("run stopped at the first wrong value");
        end
    endtask

    task automatic clear_observations();
        miss_cnt    = 0;
        mem_seen    = 1'b0;
        last_we     = 1'b0;
        fill_done   = 1'b0;
        wb_addr     = no_wb;
        ld_gnt_seen = 1'b0;
        st_gnt_seen = 1'b0;
        rv_seen     = 1'b0;
        st_at_ld    = 1'b0;
    endtask

    // outputs are settled at the falling edge, half a cycle away from any input change
    task automatic sample_cycle();
        @(negedge clk_i);
        cyc = cyc + 1;
        if (miss) miss_cnt = miss_cnt + 1;
        if (mem_req) begin
            mem_seen = 1'b1;
            last_we  = mem_we;
            // only the first writeback of a pattern is recorded
            if (mem_we && wb_addr == no_wb) wb_addr = mem_addr;
        end
        if (mem_rtrn_vld && !last_we) fill_done = 1'b1;
        if (ld_gnt && !ld_gnt_seen) begin
            ld_gnt_seen = 1'b1;
            ld_gnt_cyc  = cyc;
            st_at_ld    = st_gnt;
        end
        if (st_gnt && !st_gnt_seen) begin
            st_gnt_seen = 1'b1;
            st_gnt_cyc  = cyc;
        end
        if (ld_rvalid && !rv_seen) begin
            rv_seen = 1'b1;
            rv_cyc  = cyc;
            rv_data = ld_rdata;
        end
    endtask

    // ******************************************************************
    // one pattern row from request to completion
    // ******************************************************************

    task automatic run_pattern(int p);
        int                base;
        logic [3:0]        op;
        dcache_pkg::addr_t addr;
        logic [31:0]       exp_rdata, exp_miss, exp_wb;
        int                miss_before;
        base      = p * pat_cols;
        op        = pat_words[base][3:0];
        addr      = pat_words[base+1];
        exp_rdata = pat_words[base+4];
        exp_miss  = pat_words[base+5];
        exp_wb    = pat_words[base+6];
        cur_pat   = p + 1;
        clear_observations();

        // in the combined case both requests rise on the same edge
        @(posedge clk_i);
        #1;
        if (op[0]) begin
            ld_req  = 1'b1;
            ld_addr = addr;
        end
        if (op[1]) begin
            st_req   = 1'b1;
            st_addr  = addr;
            st_wdata = pat_words[base+2];
            st_be    = pat_words[base+3][3:0];
        end

        if (op[0]) begin
            while (!ld_gnt_seen) sample_cycle();
            @(posedge clk_i);
            #1;
            ld_req = 1'b0;
            while (!rv_seen) sample_cycle();
            check_value("load data", exp_rdata, rv_data);
        end

        if (op[1]) begin
            while (!st_gnt_seen) sample_cycle();
            @(posedge clk_i);
            #1;
            st_req      = 1'b0;
            miss_before = miss_cnt;
            fill_done   = 1'b0;
            // the LOOKUP cycle tells a store hit from a store miss
            sample_cycle();
            if (miss_cnt != miss_before) begin
                while (!fill_done) sample_cycle();
            end
        end

        check_value("miss pulses", exp_miss, miss_cnt);
        check_value("writeback address", exp_wb, wb_addr);
        if (op[0] && exp_miss == 0) begin
            check_value("hit latency in cycles", 32'd1, rv_cyc - ld_gnt_cyc);
            check_value("memory request on hit", 32'd0, {31'd0, mem_seen});
        end
        if (op == 4'd3) begin
            check_value("store grant beside load grant", 32'd0, {31'd0, st_at_ld});
            check_value("store granted after load data", 32'd1, {31'd0, st_gnt_cyc > rv_cyc});
        end
    endtask

    initial begin
        clk_i    = 1'b0;
        rst_ni   = 1'b0;
        ld_req   = 1'b0;
        ld_addr  = '0;
        st_req   = 1'b0;
        st_addr  = '0;
        st_wdata = '0;
        st_be    = '0;
        cyc      = 0;
        for (int i = 0; i < max_pat * pat_cols; i++) pat_words[i] = '0;
        $readmemh("verification/dcache_patterns.txt", pat_words);
        // an op of zero marks the end of the rows
        n_pat = 0;
        while (n_pat < max_pat && pat_words[n_pat*pat_cols] != 0) n_pat = n_pat + 1;
        if (n_pat == 0) begin
            abort_run("no patterns found in verification/dcache_patterns.txt");
        end
        cycle_limit = 40 * n_pat + 20;
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        for (int p = 0; p < n_pat; p++) run_pattern(p);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: verification/dcache_patterns.txt
// op (1 load, 2 store, 3 load and store together), byte address, store data, byte enable,
// expected load data, expected miss pulses, expected writeback line address (ffffffff for none)
1 00000104 00000000 0 5a5a0104 1 ffffffff
1 0000010c 00000000 0 5a5a010c 0 ffffffff
2 00000108 deadbeef 3 00000000 0 ffffffff
1 00000108 00000000 0 5a5abeef 0 ffffffff
2 00000224 11223344 c 00000000 1 ffffffff
1 00000224 00000000 0 11220224 0 ffffffff
1 00000228 00000000 0 5a5a0228 0 ffffffff
1 00000504 00000000 0 5a5a0504 1 00000100
1 00000108 00000000 0 5a5abeef 1 ffffffff
2 0000062c cafef00d f 00000000 1 00000220
1 0000062c 00000000 0 cafef00d 0 ffffffff
1 00000224 00000000 0 11220224 1 00000620
3 00000228 0000a5a5 1 5a5a0228 0 ffffffff
1 00000228 00000000 0 5a5a02a5 0 ffffffff
3 00000340 77777777 f 5a5a0340 1 ffffffff
1 00000340 00000000 0 77777777 0 ffffffff

// File: flist.f
design/dcache_pkg.sv
design/dcache_store_ram.sv
design/dcache_port_arbiter.sv
design/dcache_controller.sv
design/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_assert.sv
verification/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcache_tb -f flist.f -o Vdcache_tb

status=0
out=$(./obj_dir/Vdcache_tb 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
